// File: hdl/branch_cluster.sv
//##################################################
// Top level of the branch-resolution cluster. Splits
// the CDB words into plain ports and ties the station
// to the branch unit
//##################################################
`timescale 1ns/100ps

module branch_cluster (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     flush_i,

    input  logic                     issue_valid_i,
    output logic                     issue_ready_o,
    input  branch_pkg::branch_type_t branch_type_i,
    input  logic                     rs1_ready_i,
    input  branch_pkg::rob_idx_t     rs1_idx_i,
    input  branch_pkg::xlen_t        rs1_value_i,
    input  logic                     rs2_ready_i,
    input  branch_pkg::rob_idx_t     rs2_idx_i,
    input  branch_pkg::xlen_t        rs2_value_i,
    input  branch_pkg::imm_t         imm_i,
    input  branch_pkg::rob_idx_t     dest_idx_i,
    input  branch_pkg::xlen_t        pred_pc_i,
    input  branch_pkg::xlen_t        pred_target_i,
    input  logic                     pred_taken_i,

    // CDB snoop side
    input  logic                     cdb_valid_i,
    input  branch_pkg::rob_idx_t     cdb_rob_idx_i,
    input  branch_pkg::xlen_t        cdb_value_i,
    input  logic                     cdb_except_i,
    input  branch_pkg::exc_code_t    cdb_exc_code_i,

    // CDB result side
    input  logic                     cdb_ready_i,
    output logic                     cdb_valid_o,
    output branch_pkg::rob_idx_t     cdb_rob_idx_o,
    output branch_pkg::xlen_t        cdb_value_o,
    output logic                     cdb_except_o,
    output branch_pkg::exc_code_t    cdb_exc_code_o
);
    import branch_pkg::*;

    cdb_data_t cdb_in;
    cdb_data_t cdb_out;
    logic      res_valid;   // Unit to station
    logic      mispredict;

    bu_issue_if bu_if ();

    assign cdb_in.rob_idx       = cdb_rob_idx_i;
    assign cdb_in.value         = cdb_value_i;
    assign cdb_in.except_raised = cdb_except_i;
    assign cdb_in.except_code   = cdb_exc_code_i;

    branch_rs u_rs (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .issue_valid_i  (issue_valid_i),
        .issue_ready_o  (issue_ready_o),
        .branch_type_i  (branch_type_i),
        .rs1_ready_i    (rs1_ready_i),
        .rs1_idx_i      (rs1_idx_i),
        .rs1_value_i    (rs1_value_i),
        .rs2_ready_i    (rs2_ready_i),
        .rs2_idx_i      (rs2_idx_i),
        .rs2_value_i    (rs2_value_i),
        .imm_i          (imm_i),
        .dest_idx_i     (dest_idx_i),
        .pred_pc_i      (pred_pc_i),
        .pred_target_i  (pred_target_i),
        .pred_taken_i   (pred_taken_i),
        .bu             (bu_if.rs_mp),
        .bu_res_valid_i (res_valid),
        .bu_mispredict_i(mispredict),
        .cdb_valid_i    (cdb_valid_i),
        .cdb_data_i     (cdb_in),
        .cdb_ready_i    (cdb_ready_i),
        .cdb_valid_o    (cdb_valid_o),
        .cdb_data_o     (cdb_out)
    );

    branch_unit u_bu (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .bu          (bu_if.bu_mp),
        .res_valid_o (res_valid),
        .mispredict_o(mispredict)
    );

    assign cdb_rob_idx_o  = cdb_out.rob_idx;
    assign cdb_value_o    = cdb_out.value;
    assign cdb_except_o   = cdb_out.except_raised;
    assign cdb_exc_code_o = cdb_out.except_code;

endmodule

// File: hdl/branch_pkg.sv
//##################################################
// Shared widths, vector types and the CDB word used by
// the branch-resolution cluster. Modules import it
// inside their body and use scoped names in headers
//##################################################
package branch_pkg;

    // Data path widths
    localparam int XLEN         = 32;   // Integer register width
    localparam int B_IMM        = 12;   // Branch immediate, in half-words
    localparam int ROB_IDX_LEN  = 4;    // Reorder-buffer tag
    localparam int EXC_CODE_LEN = 4;

    // Reservation station geometry
    localparam int RS_DEPTH     = 4;
    localparam int RS_IDX_LEN   = 2;    // Enough to address RS_DEPTH entries

    // Vector types with a meaning
    typedef logic [XLEN-1:0]         xlen_t;
    typedef logic [B_IMM-1:0]        imm_t;
    typedef logic [ROB_IDX_LEN-1:0]  rob_idx_t;
    typedef logic [RS_IDX_LEN-1:0]   rs_idx_t;
    typedef logic [EXC_CODE_LEN-1:0] exc_code_t;

    // Conditional branch kinds handled by the branch unit
    typedef enum logic [2:0] {
        BEQ  = 3'd0,    // Equal
        BNE  = 3'd1,    // Not equal
        BLT  = 3'd2,    // Signed less than
        BGE  = 3'd3,    // Signed greater or equal
        BLTU = 3'd4,    // Unsigned less than
        BGEU = 3'd5     // Unsigned greater or equal
    } branch_type_t;

    // One CDB broadcast, 41 bits wide
    typedef struct packed {
        rob_idx_t  rob_idx;         // ROB entry the value belongs to
        xlen_t     value;           // Result word
        logic      except_raised;   // Producer hit an exception
        exc_code_t except_code;     // Cause when except_raised is set
    } cdb_data_t;

endpackage

// File: hdl/branch_rs.sv
//##################################################
// Reservation station for conditional branches.
// Snoops the CDB for missing operands, issues to the
// branch unit in order and pops results onto the CDB
// in program order
//##################################################
`timescale 1ns/100ps

module branch_rs (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     flush_i,

    input  logic                     issue_valid_i,
    output logic                     issue_ready_o,
    input  branch_pkg::branch_type_t branch_type_i,
    input  logic                     rs1_ready_i,
    input  branch_pkg::rob_idx_t     rs1_idx_i,
    input  branch_pkg::xlen_t        rs1_value_i,
    input  logic                     rs2_ready_i,
    input  branch_pkg::rob_idx_t     rs2_idx_i,
    input  branch_pkg::xlen_t        rs2_value_i,
    input  branch_pkg::imm_t         imm_i,
    input  branch_pkg::rob_idx_t     dest_idx_i,
    input  branch_pkg::xlen_t        pred_pc_i,
    input  branch_pkg::xlen_t        pred_target_i,
    input  logic                     pred_taken_i,

    bu_issue_if.rs_mp                bu,
    input  logic                     bu_res_valid_i,
    input  logic                     bu_mispredict_i,

    input  logic                     cdb_valid_i,
    input  branch_pkg::cdb_data_t    cdb_data_i,
    input  logic                     cdb_ready_i,
    output logic                     cdb_valid_o,
    output branch_pkg::cdb_data_t    cdb_data_o
);
    import branch_pkg::*;

    // Per-entry status
    logic         valid_q   [RS_DEPTH];  // Entry holds a branch
    logic         busy_q    [RS_DEPTH];  // Sitting in the branch unit
    logic         done_q    [RS_DEPTH];  // Outcome written back
    logic         rs1_rdy_q [RS_DEPTH];
    logic         rs2_rdy_q [RS_DEPTH];

    // Per-entry payload
    branch_type_t type_q    [RS_DEPTH];
    rob_idx_t     rs1_idx_q [RS_DEPTH];  // Producer tag of operand 1
    xlen_t        rs1_val_q [RS_DEPTH];
    rob_idx_t     rs2_idx_q [RS_DEPTH];
    xlen_t        rs2_val_q [RS_DEPTH];
    imm_t         imm_q     [RS_DEPTH];
    xlen_t        pc_q      [RS_DEPTH];
    xlen_t        tgt_q     [RS_DEPTH];
    logic         ptaken_q  [RS_DEPTH];
    rob_idx_t     dest_q    [RS_DEPTH];  // ROB slot of the branch
    logic         mispred_q [RS_DEPTH];

    // Wrapping pointers, all move forward in program order
    rs_idx_t      tail_q;       // Next free slot
    rs_idx_t      issue_q;      // Next to send to the unit
    rs_idx_t      wb_q;         // Next to receive a result
    rs_idx_t      head_q;       // Oldest entry

    logic         push;
    logic         issue;
    logic         wr_res;
    logic         pop;
    logic         cdb_ok;       // Broadcast usable for snooping
    logic         hit1 [RS_DEPTH];
    logic         hit2 [RS_DEPTH];
    logic         push_hit1;    // Operand arrives in the push cycle
    logic         push_hit2;

    function automatic rs_idx_t next_idx(input rs_idx_t idx);
        rs_idx_t nxt;
        if (idx == rs_idx_t'(RS_DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = idx + rs_idx_t'(1);
        end
        return nxt;
    endfunction

    // Exceptional broadcasts carry no usable value
    assign cdb_ok = cdb_valid_i & ~cdb_data_i.except_raised;

    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            hit1[i] = cdb_ok & valid_q[i] & ~rs1_rdy_q[i]
                      & (rs1_idx_q[i] == cdb_data_i.rob_idx);
            hit2[i] = cdb_ok & valid_q[i] & ~rs2_rdy_q[i]
                      & (rs2_idx_q[i] == cdb_data_i.rob_idx);
        end
    end

    // Forward a broadcast that lands together with the push
    assign push_hit1 = cdb_ok & ~rs1_ready_i & (rs1_idx_i == cdb_data_i.rob_idx);
    assign push_hit2 = cdb_ok & ~rs2_ready_i & (rs2_idx_i == cdb_data_i.rob_idx);

    assign issue_ready_o = ~valid_q[tail_q];           // Tail slot free
    assign push          = issue_valid_i & issue_ready_o;

    // Offer the oldest unissued branch once both operands are in
    assign bu.valid = valid_q[issue_q] & ~busy_q[issue_q] & ~done_q[issue_q]
                      & rs1_rdy_q[issue_q] & rs2_rdy_q[issue_q];
    assign issue    = bu.valid & bu.ready;

    assign wr_res      = bu_res_valid_i & busy_q[wb_q]; // Results come back in issue order
    assign cdb_valid_o = valid_q[head_q] & done_q[head_q];
    assign pop         = cdb_valid_o & cdb_ready_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tail_q  <= '0;
            issue_q <= '0;
            wb_q    <= '0;
            head_q  <= '0;
            for (int i = 0; i < RS_DEPTH; i++) begin
                valid_q[i]   <= 1'b0;
                busy_q[i]    <= 1'b0;
                done_q[i]    <= 1'b0;
                rs1_rdy_q[i] <= 1'b0;
                rs2_rdy_q[i] <= 1'b0;
            end
        end else if (flush_i) begin
            tail_q  <= '0;
            issue_q <= '0;
            wb_q    <= '0;
            head_q  <= '0;
            for (int i = 0; i < RS_DEPTH; i++) begin
                valid_q[i]   <= 1'b0;
                busy_q[i]    <= 1'b0;
                done_q[i]    <= 1'b0;
                rs1_rdy_q[i] <= 1'b0;
                rs2_rdy_q[i] <= 1'b0;
            end
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (hit1[i]) begin
                    rs1_rdy_q[i] <= 1'b1;
                end
                if (hit2[i]) begin
                    rs2_rdy_q[i] <= 1'b1;
                end
            end
            if (push) begin
                valid_q[tail_q]   <= 1'b1;
                busy_q[tail_q]    <= 1'b0;
                done_q[tail_q]    <= 1'b0;
                rs1_rdy_q[tail_q] <= rs1_ready_i | push_hit1;
                rs2_rdy_q[tail_q] <= rs2_ready_i | push_hit2;
                tail_q            <= next_idx(tail_q);
            end
            if (issue) begin
                busy_q[issue_q] <= 1'b1;    // Keeps it from being offered twice
                issue_q         <= next_idx(issue_q);
            end
            if (wr_res) begin
                busy_q[wb_q] <= 1'b0;
                done_q[wb_q] <= 1'b1;
                wb_q         <= next_idx(wb_q);
            end
            if (pop) begin
                valid_q[head_q] <= 1'b0;    // Slot free for a new push
                done_q[head_q]  <= 1'b0;
                head_q          <= next_idx(head_q);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (hit1[i]) begin
                rs1_val_q[i] <= cdb_data_i.value;
            end
            if (hit2[i]) begin
                rs2_val_q[i] <= cdb_data_i.value;
            end
        end
        if (push) begin
            type_q[tail_q]    <= branch_type_i;
            rs1_idx_q[tail_q] <= rs1_idx_i;
            rs1_val_q[tail_q] <= push_hit1 ? cdb_data_i.value : rs1_value_i;
            rs2_idx_q[tail_q] <= rs2_idx_i;
            rs2_val_q[tail_q] <= push_hit2 ? cdb_data_i.value : rs2_value_i;
            imm_q[tail_q]     <= imm_i;
            pc_q[tail_q]      <= pred_pc_i;
            tgt_q[tail_q]     <= pred_target_i;
            ptaken_q[tail_q]  <= pred_taken_i;
            dest_q[tail_q]    <= dest_idx_i;
        end
        if (wr_res) begin
            mispred_q[wb_q] <= bu_mispredict_i;
        end
    end

    // Branch offered to the unit
    assign bu.branch_type = type_q[issue_q];
    assign bu.rs1         = rs1_val_q[issue_q];
    assign bu.rs2         = rs2_val_q[issue_q];
    assign bu.imm         = imm_q[issue_q];
    assign bu.pred_pc     = pc_q[issue_q];
    assign bu.pred_target = tgt_q[issue_q];
    assign bu.pred_taken  = ptaken_q[issue_q];

    // Result word, misprediction flag in bit 0
    assign cdb_data_o.rob_idx       = dest_q[head_q];
    assign cdb_data_o.value         = {{(XLEN-1){1'b0}}, mispred_q[head_q]};
    assign cdb_data_o.except_raised = 1'b0;     // Conditional branches never fault here
    assign cdb_data_o.except_code   = '0;

endmodule

// File: hdl/branch_unit.sv
//##################################################
// One-deep branch resolution stage. Takes a branch
// from the station, evaluates the condition and
// target, returns the misprediction flag next cycle
//##################################################
`timescale 1ns/100ps

module branch_unit (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        flush_i,
    bu_issue_if.bu_mp   bu,
    output logic        res_valid_o,   // One-cycle pulse per resolved branch
    output logic        mispredict_o
);
    import branch_pkg::*;

    logic  taken;           // Real direction
    xlen_t offset;          // Sign-extended immediate times two
    xlen_t target;          // Real target when taken
    logic  mispredict_d;
    logic  accept;
    logic  res_valid_q;
    logic  mispredict_q;

    // Condition evaluation
    always_comb begin
        case (bu.branch_type)
            BEQ:     taken = (bu.rs1 == bu.rs2);
            BNE:     taken = (bu.rs1 != bu.rs2);
            BLT:     taken = ($signed(bu.rs1) <  $signed(bu.rs2));
            BGE:     taken = ($signed(bu.rs1) >= $signed(bu.rs2));
            BLTU:    taken = (bu.rs1 <  bu.rs2);
            BGEU:    taken = (bu.rs1 >= bu.rs2);
            default: taken = 1'b0;  // Unused encodings fall through
        endcase
    end

    assign offset = {{(XLEN-B_IMM-1){bu.imm[B_IMM-1]}}, bu.imm, 1'b0};
    assign target = bu.pred_pc + offset;

    // Wrong direction, or right direction but wrong place
    assign mispredict_d = (taken != bu.pred_taken)
                          | (taken & (target != bu.pred_target));

    // Result register drains every cycle since the station always takes it
    assign bu.ready = 1'b1;
    assign accept   = bu.valid & bu.ready;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            res_valid_q <= 1'b0;
        end else if (flush_i) begin
            res_valid_q <= 1'b0;    // Drop any result in flight
        end else begin
            res_valid_q <= accept;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            mispredict_q <= mispredict_d;
        end
    end

    assign res_valid_o  = res_valid_q;
    assign mispredict_o = mispredict_q;

endmodule

// File: hdl/bu_issue_if.sv
//##################################################
// Issue path from the branch reservation station to
// the branch unit. Valid/ready handshake plus the
// operands and prediction of one branch
//##################################################
`timescale 1ns/100ps

interface bu_issue_if;
    import branch_pkg::*;

    logic         valid;        // Station offers a branch, never waits on ready
    logic         ready;        // Unit can take it this cycle
    branch_type_t branch_type;
    xlen_t        rs1;          // First operand
    xlen_t        rs2;          // Second operand
    imm_t         imm;          // Offset in half-words
    xlen_t        pred_pc;      // PC of the branch itself
    xlen_t        pred_target;  // Target guessed by fetch
    logic         pred_taken;   // Direction guessed by fetch

    // Station side
    modport rs_mp (
        output valid, branch_type, rs1, rs2, imm, pred_pc, pred_target, pred_taken,
        input  ready
    );

    // Branch unit side
    modport bu_mp (
        input  valid, branch_type, rs1, rs2, imm, pred_pc, pred_target, pred_taken,
        output ready
    );

endinterface

// File: sim/branch_cluster_assertions.sv
//##################################################
// Concurrent checks on the cluster's top-level ports,
// bound into every branch_cluster instance
//##################################################
`timescale 1ns/100ps

module branch_cluster_assertions (
    input logic                  clk_i,
    input logic                  rst_n_i,
    input logic                  flush_i,
    input logic                  cdb_ready_i,
    input logic                  cdb_valid_o,
    input branch_pkg::rob_idx_t  cdb_rob_idx_o,
    input branch_pkg::xlen_t     cdb_value_o,
    input logic                  cdb_except_o,
    input branch_pkg::exc_code_t cdb_exc_code_o
);
    int fail_count = 0;     // Failed assertions so far

    // Result held while the consumer stalls, a flush may drop it
    property hold_while_stalled;
        @(posedge clk_i) disable iff (!rst_n_i)
        (cdb_valid_o && !cdb_ready_i && !flush_i) |=>
            (cdb_valid_o && $stable(cdb_rob_idx_o) && $stable(cdb_value_o)
             && $stable(cdb_except_o) && $stable(cdb_exc_code_o));
    endproperty

    a_hold: assert property (hold_while_stalled)
        else begin
            $error("CDB result changed while cdb_ready_i was low");
            fail_count++;
        end

    a_reset: assert property (@(posedge clk_i) !rst_n_i |-> !cdb_valid_o)
        else begin
            $error("cdb_valid_o high during reset");
            fail_count++;
        end

    // Conditional branches never report a fault
    a_no_except: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                                  !cdb_except_o && (cdb_exc_code_o == '0))
        else begin
            $error("exception raised on the CDB output");
            fail_count++;
        end

endmodule

bind branch_cluster branch_cluster_assertions u_assertions (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .flush_i        (flush_i),
    .cdb_ready_i    (cdb_ready_i),
    .cdb_valid_o    (cdb_valid_o),
    .cdb_rob_idx_o  (cdb_rob_idx_o),
    .cdb_value_o    (cdb_value_o),
    .cdb_except_o   (cdb_except_o),
    .cdb_exc_code_o (cdb_exc_code_o)
);

// File: sim/branch_cluster_tb.sv
//##################################################
// Testbench for the branch-resolution cluster. Runs a
// table of branches through the DUT in groups, models
// the CDB and checks every result against the table
//##################################################
`timescale 1ns/100ps

module branch_cluster_tb;
    import branch_pkg::*;

    localparam int NUM_ROWS   = 15;
    localparam int WAIT_LIMIT = 100;    // Cycles a single wait may take
    localparam int RUN_LIMIT  = 5000;   // Whole run

    // One branch with its operand timing and expected outcome
    typedef struct packed {
        branch_type_t kind;
        xlen_t        a;          // rs1 value
        logic         a_rdy;
        rob_idx_t     a_tag;
        xlen_t        b;          // rs2 value
        logic         b_rdy;
        rob_idx_t     b_tag;
        imm_t         imm;
        xlen_t        pc;
        xlen_t        tgt;        // Predicted target
        logic         ptaken;
        rob_idx_t     dest;
        logic [3:0]   delay;      // Cycles before the CDB sends missing operands
        logic [3:0]   stall;      // Cycles cdb_ready_i stays low on the result
        logic         exc_first;  // Faulting broadcast of rs1 before the clean one
        logic         exp_mis;    // Worked out by hand from the resolution rules
        logic         last;       // Closes a group
        logic         fill;       // Group fills the station
    } row_t;

    logic         clk_i;
    logic         rst_n_i;
    logic         flush_i;
    logic         issue_valid_i;
    logic         issue_ready_o;
    branch_type_t branch_type_i;
    logic         rs1_ready_i;
    rob_idx_t     rs1_idx_i;
    xlen_t        rs1_value_i;
    logic         rs2_ready_i;
    rob_idx_t     rs2_idx_i;
    xlen_t        rs2_value_i;
    imm_t         imm_i;
    rob_idx_t     dest_idx_i;
    xlen_t        pred_pc_i;
    xlen_t        pred_target_i;
    logic         pred_taken_i;
    logic         cdb_valid_i;
    rob_idx_t     cdb_rob_idx_i;
    xlen_t        cdb_value_i;
    logic         cdb_except_i;
    exc_code_t    cdb_exc_code_i;
    logic         cdb_ready_i;
    logic         cdb_valid_o;
    rob_idx_t     cdb_rob_idx_o;
    xlen_t        cdb_value_o;
    logic         cdb_except_o;
    exc_code_t    cdb_exc_code_o;

    row_t stim [NUM_ROWS];
    int   checks    = 0;
    int   errors    = 0;
    logic run_done  = 1'b0;
    logic timed_out = 1'b0;

    branch_cluster dut (.*);

    initial clk_i = 1'b0;
    always #10 clk_i = ~clk_i;  // 20 ns period

    task automatic check_rob_idx(input string name, input rob_idx_t got, input rob_idx_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %0s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_value(input string name, input xlen_t got, input xlen_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %0s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %0s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic give_up(input string what);
        $display("timeout: %0s did not happen within %0d cycles", what, WAIT_LIMIT);
        timed_out = 1'b1;
        run_done  = 1'b1;
        forever @(negedge clk_i);   // Parked, the report process ends the run
    endtask

    task automatic wait_issue_ready();
        int n;
        n = 0;
        while (!issue_ready_o) begin
            if (n == WAIT_LIMIT) give_up("issue_ready_o going high");
            @(negedge clk_i);
            n++;
        end
    endtask

    task automatic wait_cdb_valid();
        int n;
        n = 0;
        while (!cdb_valid_o) begin
            if (n == WAIT_LIMIT) give_up("a result on the CDB");
            @(negedge clk_i);
            n++;
        end
    endtask

    task automatic set_row(input int i, input branch_type_t kind,
                           input xlen_t a, input logic a_rdy, input rob_idx_t a_tag,
                           input xlen_t b, input logic b_rdy, input rob_idx_t b_tag,
                           input imm_t imm, input xlen_t pc, input xlen_t tgt,
                           input logic ptaken, input rob_idx_t dest,
                           input logic [3:0] delay, input logic [3:0] stall,
                           input logic exc_first, input logic exp_mis,
                           input logic last, input logic fill);
        stim[i] = {kind, a, a_rdy, a_tag, b, b_rdy, b_tag, imm, pc, tgt, ptaken, dest,
                   delay, stall, exc_first, exp_mis, last, fill};
    endtask

    task automatic load_rows();
        // Six kinds, ready operands; signed against unsigned on opposite signs
        set_row(0, BEQ, 32'h5, 1, 0, 32'h5, 1, 0, 12'h010, 32'h1000, 32'h1020, 1, 4'h1,
                0, 2, 0, 0, 0, 0);
        set_row(1, BNE, 32'h5, 1, 0, 32'h5, 1, 0, 12'h010, 32'h1000, 32'h1020, 1, 4'h2,
                0, 0, 0, 1, 0, 0);
        set_row(2, BLT, 32'hffff_ffff, 1, 0, 32'h1, 1, 0, 12'h010, 32'h1000, 32'h1020, 1, 4'h3,
                0, 0, 0, 0, 0, 0);
        set_row(3, BLTU, 32'hffff_ffff, 1, 0, 32'h1, 1, 0, 12'h010, 32'h1000, 32'h1020, 1, 4'h4,
                0, 0, 0, 1, 1, 0);
        set_row(4, BGE, 32'hffff_ffff, 1, 0, 32'h1, 1, 0, 12'h010, 32'h1000, 32'h1020, 0, 4'h5,
                0, 0, 0, 0, 0, 0);
        set_row(5, BGEU, 32'hffff_ffff, 1, 0, 32'h1, 1, 0, 12'h010, 32'h1000, 32'h1020, 0, 4'h6,
                0, 0, 0, 1, 0, 0);
        // Right direction, wrong target
        set_row(6, BEQ, 32'h7, 1, 0, 32'h7, 1, 0, 12'h010, 32'h1000, 32'h1024, 1, 4'h7,
                0, 0, 0, 1, 0, 0);
        set_row(7, BGE, 32'h3, 1, 0, 32'h3, 1, 0, 12'hff8, 32'h1000, 32'h0ff0, 1, 4'h8,
                0, 0, 0, 0, 1, 0);
        // Late operands from the CDB, the oldest waits longest
        set_row(8, BNE, 32'ha, 0, 3, 32'h9, 1, 0, 12'h010, 32'h1000, 32'h1020, 1, 4'h9,
                6, 0, 1, 0, 0, 0);
        set_row(9, BLTU, 32'h2, 1, 0, 32'h8, 1, 0, 12'h010, 32'h1000, 32'h1020, 0, 4'ha,
                0, 3, 0, 1, 0, 0);
        set_row(10, BGE, 32'h4, 1, 0, 32'h8000_0000, 0, 5, 12'h010, 32'h1000, 32'h1020, 1, 4'hb,
                2, 0, 0, 0, 1, 0);
        // Fills the station while the CDB is held
        set_row(11, BEQ, 32'h1, 1, 0, 32'h2, 1, 0, 12'h010, 32'h1000, 32'h1020, 0, 4'hc,
                0, 5, 0, 0, 0, 0);
        set_row(12, BNE, 32'h1, 1, 0, 32'h2, 1, 0, 12'h010, 32'h1000, 32'h1020, 1, 4'hd,
                0, 0, 0, 0, 0, 0);
        set_row(13, BLT, 32'h2, 1, 0, 32'h1, 1, 0, 12'h010, 32'h1000, 32'h1020, 1, 4'he,
                0, 0, 0, 1, 0, 0);
        set_row(14, BGEU, 32'h0, 1, 0, 32'h0, 1, 0, 12'h010, 32'h1000, 32'h1000, 1, 4'hf,
                0, 0, 0, 1, 1, 1);
    endtask

    task automatic push_row(input int i);
        wait_issue_ready();
        issue_valid_i = 1'b1;
        branch_type_i = stim[i].kind;
        rs1_ready_i   = stim[i].a_rdy;
        rs1_idx_i     = stim[i].a_tag;
        rs1_value_i   = stim[i].a_rdy ? stim[i].a : '0;  // Unknown until the CDB sends it
        rs2_ready_i   = stim[i].b_rdy;
        rs2_idx_i     = stim[i].b_tag;
        rs2_value_i   = stim[i].b_rdy ? stim[i].b : '0;
        imm_i         = stim[i].imm;
        dest_idx_i    = stim[i].dest;
        pred_pc_i     = stim[i].pc;
        pred_target_i = stim[i].tgt;
        pred_taken_i  = stim[i].ptaken;
        @(negedge clk_i);
        issue_valid_i = 1'b0;
    endtask

    task automatic broadcast(input rob_idx_t tag, input xlen_t value, input logic exc);
        cdb_valid_i    = 1'b1;
        cdb_rob_idx_i  = tag;
        cdb_value_i    = value;
        cdb_except_i   = exc;
        cdb_exc_code_i = exc ? 4'h2 : 4'h0;
        @(negedge clk_i);
        cdb_valid_i    = 1'b0;
        cdb_except_i   = 1'b0;
    endtask

    // CDB model for the producers of missing operands
    task automatic supply_operands(input int i);
        if (!stim[i].a_rdy || !stim[i].b_rdy) begin
            repeat (stim[i].delay) @(negedge clk_i);
            if (!stim[i].a_rdy) begin
                if (stim[i].exc_first) begin
                    broadcast(stim[i].a_tag, stim[i].b, 1'b1);  // Would flip the outcome
                    repeat (4) @(negedge clk_i);
                    check_flag("cdb_valid_o", cdb_valid_o, 1'b0);
                end
                broadcast(stim[i].a_tag, stim[i].a, 1'b0);
            end
            if (!stim[i].b_rdy) broadcast(stim[i].b_tag, stim[i].b, 1'b0);
        end
    endtask

    task automatic collect_result(input int i);
        rob_idx_t held_idx;
        xlen_t    held_val;
        wait_cdb_valid();
        held_idx = cdb_rob_idx_o;
        held_val = cdb_value_o;
        repeat (stim[i].stall) begin
            @(negedge clk_i);
            check_flag("cdb_valid_o", cdb_valid_o, 1'b1);
            check_rob_idx("cdb_rob_idx_o", cdb_rob_idx_o, held_idx);
            check_value("cdb_value_o", cdb_value_o, held_val);
        end
        check_rob_idx("cdb_rob_idx_o", cdb_rob_idx_o, stim[i].dest);
        check_value("cdb_value_o", cdb_value_o, {{(XLEN-1){1'b0}}, stim[i].exp_mis});
        check_flag("cdb_except_o", cdb_except_o, 1'b0);
        cdb_ready_i = 1'b1;     // Pop at the next rising edge
        @(negedge clk_i);
        cdb_ready_i = 1'b0;
    endtask

    task automatic run_group(input int first, input int last);
        for (int i = first; i <= last; i++) push_row(i);
        if (stim[last].fill) check_flag("issue_ready_o", issue_ready_o, 1'b0);
        for (int i = first; i <= last; i++) supply_operands(i);
        for (int i = first; i <= last; i++) collect_result(i);
    endtask

    task automatic report_test(input string name, input int err_before);
        $display("test %0s: %0s", name, (errors == err_before) ? "ok" : "wrong");
    endtask

    // Station full and one result still in flight when the flush lands
    task automatic flush_test();
        int err0;
        err0 = errors;
        for (int i = 0; i < RS_DEPTH; i++) push_row(i);
        check_flag("issue_ready_o", issue_ready_o, 1'b0);
        flush_i = 1'b1;
        @(negedge clk_i);
        flush_i     = 1'b0;
        cdb_ready_i = 1'b1;
        repeat (8) begin
            @(negedge clk_i);
            check_flag("cdb_valid_o", cdb_valid_o, 1'b0);
            check_flag("issue_ready_o", issue_ready_o, 1'b1);
        end
        cdb_ready_i = 1'b0;
        push_row(6);            // Station works again after the flush
        collect_result(6);
        report_test("flush", err0);
    endtask

    initial begin : stimulus
        int first;
        int err0;
        rst_n_i        = 1'b0;
        flush_i        = 1'b0;
        issue_valid_i  = 1'b0;
        branch_type_i  = BEQ;
        rs1_ready_i    = 1'b0;
        rs1_idx_i      = '0;
        rs1_value_i    = '0;
        rs2_ready_i    = 1'b0;
        rs2_idx_i      = '0;
        rs2_value_i    = '0;
        imm_i          = '0;
        dest_idx_i     = '0;
        pred_pc_i      = '0;
        pred_target_i  = '0;
        pred_taken_i   = 1'b0;
        cdb_valid_i    = 1'b0;
        cdb_rob_idx_i  = '0;
        cdb_value_i    = '0;
        cdb_except_i   = 1'b0;
        cdb_exc_code_i = '0;
        cdb_ready_i    = 1'b0;
        load_rows();
        repeat (16) @(negedge clk_i);
        rst_n_i = 1'b1;
        @(negedge clk_i);
        err0 = errors;
        check_flag("cdb_valid_o", cdb_valid_o, 1'b0);
        check_flag("issue_ready_o", issue_ready_o, 1'b1);
        report_test("reset state", err0);
        first = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (stim[i].last) begin
                err0 = errors;
                run_group(first, i);
                report_test($sformatf("rows %0d to %0d", first, i), err0);
                first = i + 1;
            end
        end
        flush_test();
        run_done = 1'b1;
    end

    initial begin : report
        int cycles;
        int fails;
        cycles = 0;
        while (!run_done && cycles < RUN_LIMIT) begin
            @(negedge clk_i);
            cycles++;
        end
        if (!run_done) begin
            $display("timeout: the run did not finish within %0d cycles", RUN_LIMIT);
            timed_out = 1'b1;
        end
        fails = dut.u_assertions.fail_count;
        $display("%0d checks, %0d errors, %0d assertion failures", checks, errors, fails);
        if (errors == 0 && fails == 0 && !timed_out) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
hdl/branch_pkg.sv
hdl/bu_issue_if.sv
hdl/branch_rs.sv
hdl/branch_unit.sv
hdl/branch_cluster.sv
sim/branch_cluster_assertions.sv
sim/branch_cluster_tb.sv
